//--- source/icache_params.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Geometry of the instruction cache
// Included by the package and by every block that slices addresses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Physical address width
`define ICACHE_AW       32

`define ICACHE_P_LINE   5   // 32-byte lines
`define ICACHE_P_SETS   6
`define ICACHE_P_WAYS   1   // Two ways
`define ICACHE_P_WIN    3   // 64-bit window, same as one AXI beat

// Derived counts
`define ICACHE_NWAYS    (1 << `ICACHE_P_WAYS)
`define ICACHE_SETS     (1 << `ICACHE_P_SETS)

// Beats per line, 4 with the sizes above
`define ICACHE_BEATS    (1 << (`ICACHE_P_LINE - `ICACHE_P_WIN))

`endif

//--- source/icache_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types shared by the cache controller, way array and RAM bus
// Referenced by scoped name from each block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "icache_params.svh"

package icache_pkg;

   typedef logic [`ICACHE_AW-1:0] paddr_t;
   typedef logic [`ICACHE_AW-`ICACHE_P_SETS-`ICACHE_P_LINE-1:0] tag_t;
   typedef logic [`ICACHE_P_SETS-1:0] set_idx_t;
   typedef logic [`ICACHE_P_SETS+`ICACHE_P_LINE-`ICACHE_P_WIN-1:0] data_addr_t; // {set, beat}
   typedef logic [`ICACHE_P_LINE-`ICACHE_P_WIN-1:0] beat_t;
   typedef logic [`ICACHE_P_WAYS-1:0] way_t;
   typedef logic [(8 << `ICACHE_P_WIN)-1:0] window_t; // Two instructions

   // One tag RAM word
   typedef struct packed {
      tag_t tag;
      logic valid;
   } tag_entry_t;

   typedef enum logic [2:0] {
      BOOT,
      IDLE,
      REPLACE,
      REFILL,
      INVALIDATE,
      RELOAD      // Re-read stage 1 after the RAMs changed
   } fsm_state_t;

endpackage

`default_nettype wire

//--- source/icache_ram_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RAM port bundle from the controller to the way array
// Writes land at the clock edge, reads return one cycle after re
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "icache_params.svh"

interface icache_ram_if;
   logic                        re;         // Shared by tag and data RAMs
   icache_pkg::set_idx_t        set_idx;
   logic [`ICACHE_NWAYS-1:0]    tag_we;
   icache_pkg::tag_entry_t      tag_din;
   icache_pkg::data_addr_t      data_addr;
   logic [`ICACHE_NWAYS-1:0]    data_we;    // Victim way only
   icache_pkg::window_t         data_din;

   modport ctrl (
      output re, set_idx, tag_we, tag_din,
      output data_addr, data_we, data_din
   );

   modport ways (
      input re, set_idx, tag_we, tag_din,
      input data_addr, data_we, data_din
   );

endinterface

`default_nettype wire

//--- source/icache_sram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-port synchronous RAM with registered read
// Word type set by parameter, used for tags and for windows
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module icache_sram #(
   parameter type entry_t = logic [31:0],
   parameter int  DEPTH   = 64
) (
   input  wire                       clk,
   input  wire                       re_i,
   input  wire [$clog2(DEPTH)-1:0]   addr_i,
   input  wire                       we_i,
   input  wire entry_t               din_i,
   output entry_t                    dout_o
);

   entry_t mem [DEPTH];

   always_ff @(posedge clk)
   begin
      if (we_i)
         mem[addr_i] <= din_i;
      // Old contents on a same-cycle write
      if (re_i)
         dout_o <= mem[addr_i];   // Keeps last word while re_i is low
   end

endmodule

`default_nettype wire

//--- source/icache_ways.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Way array with stage-1 registers and the stage-2 tag compare
// RAM ports come from the controller over icache_ram_if
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "icache_params.svh"

module icache_ways (
   input  wire                           clk,
   input  wire                           rst_n_i,
   input  wire                           advance_i,
   input  wire icache_pkg::paddr_t       fetch_addr_i,
   input  wire icache_pkg::paddr_t       inv_addr_i,
   icache_ram_if.ways                    ram,
   output logic                          s1_valid_o,
   output icache_pkg::paddr_t            s1_addr_o,
   output icache_pkg::set_idx_t          s1_set_o,
   output icache_pkg::data_addr_t        s1_data_addr_o,
   output icache_pkg::paddr_t            s1_inv_addr_o,
   output logic                          hit_o,
   output icache_pkg::window_t           hit_win_o
);

   localparam int TAG_LSB = `ICACHE_P_LINE + `ICACHE_P_SETS;

   icache_pkg::tag_entry_t     tag_rd [`ICACHE_NWAYS];
   icache_pkg::window_t        win_rd [`ICACHE_NWAYS];
   logic [`ICACHE_NWAYS-1:0]   hit_vec;
   icache_pkg::way_t           hit_way;
   icache_pkg::tag_t           s1_tag;

   for (genvar w = 0; w < `ICACHE_NWAYS; w++)
   begin : g_way
      icache_sram #(
         .entry_t (icache_pkg::tag_entry_t),
         .DEPTH   (`ICACHE_SETS)
      ) tag_ram_inst (
         .clk    (clk),
         .re_i   (ram.re),
         .addr_i (ram.set_idx),
         .we_i   (ram.tag_we[w]),
         .din_i  (ram.tag_din),
         .dout_o (tag_rd[w])
      );

      icache_sram #(
         .entry_t (icache_pkg::window_t),
         .DEPTH   (`ICACHE_SETS * `ICACHE_BEATS)
      ) data_ram_inst (
         .clk    (clk),
         .re_i   (ram.re),
         .addr_i (ram.data_addr),
         .we_i   (ram.data_we[w]),
         .din_i  (ram.data_din),
         .dout_o (win_rd[w])
      );

      assign hit_vec[w] = tag_rd[w].valid && (tag_rd[w].tag == s1_tag);
   end

   // Stage 1
   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
         s1_valid_o <= 1'b0;
      else if (advance_i)
         s1_valid_o <= 1'b1;   // Every unstalled cycle is a fetch
   end

   always_ff @(posedge clk)
   begin
      if (advance_i)
      begin
         s1_addr_o      <= fetch_addr_i;
         s1_inv_addr_o  <= inv_addr_i;
         s1_set_o       <= ram.set_idx;     // Kept for RELOAD
         s1_data_addr_o <= ram.data_addr;
      end
   end

   // Stage 2, compare and pick the hitting way
   assign s1_tag = s1_addr_o[`ICACHE_AW-1:TAG_LSB];

   always_comb
   begin
      hit_way = '0;
      for (int w = `ICACHE_NWAYS - 1; w >= 0; w--)
         if (hit_vec[w])
            hit_way = icache_pkg::way_t'(w);   // Lowest way wins
   end

   assign hit_o     = |hit_vec;
   assign hit_win_o = win_rd[hit_way];

   // A line lives in one way only, refill and RELOAD must keep it so
   a_one_hit : assert property (@(posedge clk) disable iff (!rst_n_i)
      s1_valid_o |-> $onehot0(hit_vec));

endmodule

`default_nettype wire

//--- source/icache_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache controller with the boot, lookup, refill and invalidate FSM
// Drives the RAM ports, the output window and the AXI read master
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "icache_params.svh"

module icache_ctrl (
   input  wire                           clk,
   input  wire                           rst_n_i,
   input  wire icache_pkg::paddr_t       fetch_addr_i,
   input  wire                           inv_i,
   input  wire                           s1_valid_i,
   input  wire icache_pkg::paddr_t       s1_addr_i,
   input  wire icache_pkg::set_idx_t     s1_set_i,
   input  wire icache_pkg::data_addr_t   s1_data_addr_i,
   input  wire icache_pkg::paddr_t       s1_inv_addr_i,
   input  wire                           hit_i,
   input  wire icache_pkg::window_t      hit_win_i,
   icache_ram_if.ctrl                    ram,
   output logic                          advance_o,
   output logic                          stall_o,
   output logic                          op_stall_o,
   output icache_pkg::window_t           ins_o,
   output logic                          valid_o,
   input  wire                           ar_ready_i,
   output logic                          ar_valid_o,
   output icache_pkg::paddr_t            ar_addr_o,
   input  wire                           r_valid_i,
   input  wire icache_pkg::window_t      r_data_i,
   input  wire                           r_last_i,
   output logic                          r_ready_o
);

   localparam int SET_LSB  = `ICACHE_P_LINE;
   localparam int TAG_LSB  = `ICACHE_P_LINE + `ICACHE_P_SETS;
   localparam int BEAT_LSB = `ICACHE_P_WIN;

   icache_pkg::fsm_state_t   state_q;
   icache_pkg::fsm_state_t   state_d;
   icache_pkg::set_idx_t     boot_cnt_q;
   icache_pkg::way_t         victim_q;      // Round-robin pointer
   icache_pkg::beat_t        beat_q;
   logic                     s2_valid_q;
   logic                     s2_miss_q;
   icache_pkg::paddr_t       s2_addr_q;
   logic                     miss;
   logic                     r_hs;
   logic                     r_done;
   logic                     get_beat;

   assign stall_o    = (state_q != icache_pkg::IDLE);
   assign advance_o  = ~stall_o;
   assign op_stall_o = inv_i | stall_o;
   assign valid_o    = s2_valid_q & ~stall_o;
   assign miss       = s1_valid_i & ~hit_i;

   assign r_ready_o  = (state_q == icache_pkg::REFILL);
   assign r_hs       = r_valid_i & r_ready_o;
   assign r_done     = r_hs & r_last_i;
   assign get_beat   = r_hs & (beat_q == s2_addr_q[BEAT_LSB +: $bits(icache_pkg::beat_t)]);

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         icache_pkg::BOOT:
            if (boot_cnt_q == '1)
               state_d = icache_pkg::IDLE;
         icache_pkg::IDLE:
            if (inv_i)
               state_d = icache_pkg::INVALIDATE;
            else if (miss)
               state_d = icache_pkg::REPLACE;
         icache_pkg::REPLACE:
            state_d = icache_pkg::REFILL;
         icache_pkg::REFILL:
            if (r_done)
               state_d = icache_pkg::RELOAD;
         icache_pkg::INVALIDATE:   // A miss seen with the pulse is served next
            state_d = s2_miss_q ? icache_pkg::REPLACE : icache_pkg::IDLE;
         icache_pkg::RELOAD:
            state_d = icache_pkg::IDLE;
         default:
            state_d = icache_pkg::BOOT;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         state_q    <= icache_pkg::BOOT;
         boot_cnt_q <= '0;
         victim_q   <= '0;
         beat_q     <= '0;
      end
      else
      begin
         state_q <= state_d;
         if (state_q == icache_pkg::BOOT)
            boot_cnt_q <= boot_cnt_q + 1'b1;
         if (r_done)
            victim_q <= victim_q + 1'b1;
         if (state_q != icache_pkg::REFILL)
            beat_q <= '0;
         else if (r_hs)
            beat_q <= beat_q + 1'b1;
      end
   end

   // Stage 2 registers and output window
   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         s2_valid_q <= 1'b0;
         s2_miss_q  <= 1'b0;
      end
      else if (advance_o)
      begin
         s2_valid_q <= s1_valid_i;
         s2_miss_q  <= miss;
      end
   end

   always_ff @(posedge clk)
   begin
      if (advance_o)
         s2_addr_q <= s1_addr_i;
      if (advance_o)
         ins_o <= hit_win_i;
      else if (get_beat)
         ins_o <= r_data_i;   // Missed window straight off the bus
   end

   // RAM port muxes
   always_comb
   begin
      ram.re        = advance_o | (state_q == icache_pkg::RELOAD);
      ram.set_idx   = fetch_addr_i[SET_LSB +: `ICACHE_P_SETS];
      ram.tag_din   = '0;                       // Boot and invalidate clear
      ram.data_addr = fetch_addr_i[BEAT_LSB +: $bits(icache_pkg::data_addr_t)];
      ram.data_din  = r_data_i;
      case (state_q)
         icache_pkg::BOOT:
            ram.set_idx = boot_cnt_q;
         icache_pkg::INVALIDATE:
            ram.set_idx = s1_inv_addr_i[SET_LSB +: `ICACHE_P_SETS];
         icache_pkg::REPLACE:
         begin
            ram.set_idx       = s2_addr_q[SET_LSB +: `ICACHE_P_SETS];
            ram.tag_din.tag   = s2_addr_q[`ICACHE_AW-1:TAG_LSB];
            ram.tag_din.valid = 1'b1;
         end
         icache_pkg::REFILL:
            ram.data_addr = {s2_addr_q[SET_LSB +: `ICACHE_P_SETS], beat_q};
         icache_pkg::RELOAD:
         begin
            ram.set_idx   = s1_set_i;
            ram.data_addr = s1_data_addr_i;
         end
         default: ;
      endcase
   end

   always_comb
   begin
      for (int w = 0; w < `ICACHE_NWAYS; w++)
      begin
         ram.tag_we[w]  = (state_q == icache_pkg::BOOT) ||
                          (state_q == icache_pkg::INVALIDATE) ||
                          ((state_q == icache_pkg::REPLACE) &&
                           (victim_q == icache_pkg::way_t'(w)));
         ram.data_we[w] = r_hs && (victim_q == icache_pkg::way_t'(w));
      end
   end

   // AXI read address for one line-aligned burst per miss
   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
         ar_valid_o <= 1'b0;
      else if (state_q == icache_pkg::REPLACE)
         ar_valid_o <= 1'b1;
      else if (ar_ready_i)
         ar_valid_o <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (state_q == icache_pkg::REPLACE)
         ar_addr_o <= {s2_addr_q[`ICACHE_AW-1:SET_LSB], {SET_LSB{1'b0}}};
   end

   a_ar_hold : assert property (@(posedge clk) disable iff (!rst_n_i)
      ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o));

   // The last beat of the burst fills the last word of the line
   a_r_last : assert property (@(posedge clk) disable iff (!rst_n_i)
      r_done |-> (beat_q == '1));

endmodule

`default_nettype wire

//--- source/icache_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-way instruction cache with AXI read refill
// Fetch address in, 64-bit window out two cycles later on a hit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module icache_top (
   input  wire                           clk,
   input  wire                           rst_n_i,
   input  wire icache_pkg::paddr_t       fetch_addr_i,
   output logic                          stall_o,
   input  wire                           inv_i,
   input  wire icache_pkg::paddr_t       inv_addr_i,
   output logic                          op_stall_o,
   output icache_pkg::window_t           ins_o,
   output logic                          valid_o,
   input  wire                           ar_ready_i,
   output logic                          ar_valid_o,
   output icache_pkg::paddr_t            ar_addr_o,
   input  wire                           r_valid_i,
   input  wire icache_pkg::window_t      r_data_i,
   input  wire                           r_last_i,
   output logic                          r_ready_o
);

   logic                      advance;
   logic                      s1_valid;
   icache_pkg::paddr_t        s1_addr;
   icache_pkg::set_idx_t      s1_set;
   icache_pkg::data_addr_t    s1_data_addr;
   icache_pkg::paddr_t        s1_inv_addr;
   logic                      hit;
   icache_pkg::window_t       hit_win;

   icache_ram_if ram_if_inst ();

   icache_ways ways_inst (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .advance_i      (advance),
      .fetch_addr_i   (fetch_addr_i),
      .inv_addr_i     (inv_addr_i),
      .ram            (ram_if_inst.ways),
      .s1_valid_o     (s1_valid),
      .s1_addr_o      (s1_addr),
      .s1_set_o       (s1_set),
      .s1_data_addr_o (s1_data_addr),
      .s1_inv_addr_o  (s1_inv_addr),
      .hit_o          (hit),
      .hit_win_o      (hit_win)
   );

   icache_ctrl ctrl_inst (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .fetch_addr_i   (fetch_addr_i),
      .inv_i          (inv_i),
      .s1_valid_i     (s1_valid),
      .s1_addr_i      (s1_addr),
      .s1_set_i       (s1_set),
      .s1_data_addr_i (s1_data_addr),
      .s1_inv_addr_i  (s1_inv_addr),
      .hit_i          (hit),
      .hit_win_i      (hit_win),
      .ram            (ram_if_inst.ctrl),
      .advance_o      (advance),
      .stall_o        (stall_o),
      .op_stall_o     (op_stall_o),
      .ins_o          (ins_o),
      .valid_o        (valid_o),
      .ar_ready_i     (ar_ready_i),
      .ar_valid_o     (ar_valid_o),
      .ar_addr_o      (ar_addr_o),
      .r_valid_i      (r_valid_i),
      .r_data_i       (r_data_i),
      .r_last_i       (r_last_i),
      .r_ready_o      (r_ready_o)
   );

endmodule

`default_nettype wire

//--- dv/icache_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the two-way instruction cache
// Applies a table of fetches and invalidates against an AXI memory model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "icache_params.svh"

module icache_tb;

   localparam int TIMEOUT = 200;

   typedef enum logic {OP_FETCH, OP_INV} op_t;

   typedef struct {
      string              name;
      op_t                op;
      icache_pkg::paddr_t addr;
      logic               exp_ar;   // Refill burst expected
   } row_t;

   logic                  clk = 1'b0;
   logic                  rst_n_i;
   icache_pkg::paddr_t    fetch_addr_i;
   logic                  stall_o;
   logic                  inv_i;
   icache_pkg::paddr_t    inv_addr_i;
   logic                  op_stall_o;
   icache_pkg::window_t   ins_o;
   logic                  valid_o;
   logic                  ar_ready_i;
   logic                  ar_valid_o;
   icache_pkg::paddr_t    ar_addr_o;
   logic                  r_valid_i;
   icache_pkg::window_t   r_data_i;
   logic                  r_last_i;
   logic                  r_ready_o;

   row_t                  rows[$];
   icache_pkg::paddr_t    acc_q[$];     // Accepted fetches with the oldest first
   int                    acc_cyc_q[$];
   icache_pkg::paddr_t    mon_addr;
   int                    cyc = 0;
   int                    push_cnt = 0;
   int                    pop_cnt = 0;
   int                    last_lat = 0;
   int                    ar_count = 0;
   icache_pkg::paddr_t    last_ar_addr;
   string                 cur_name = "boot";
   logic                  ar_seen = 1'b0;
   logic                  ar_hs = 1'b0;
   logic                  r_hs = 1'b0;
   icache_pkg::paddr_t    ar_addr_q;
   integer                seed;
   int                    ar_delay;
   icache_pkg::paddr_t    rd_base;
   int                    rd_beat;
   logic                  rd_active;

   icache_top icache_top_inst (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .fetch_addr_i (fetch_addr_i),
      .stall_o      (stall_o),
      .inv_i        (inv_i),
      .inv_addr_i   (inv_addr_i),
      .op_stall_o   (op_stall_o),
      .ins_o        (ins_o),
      .valid_o      (valid_o),
      .ar_ready_i   (ar_ready_i),
      .ar_valid_o   (ar_valid_o),
      .ar_addr_o    (ar_addr_o),
      .r_valid_i    (r_valid_i),
      .r_data_i     (r_data_i),
      .r_last_i     (r_last_i),
      .r_ready_o    (r_ready_o)
   );

   always #10 clk = ~clk;

   // Memory contents are the address XOR a constant in both halves
   function automatic icache_pkg::window_t expect_window(input icache_pkg::paddr_t a);
      icache_pkg::paddr_t word;
      word = {a[`ICACHE_AW-1:`ICACHE_P_WIN], {`ICACHE_P_WIN{1'b0}}} ^ 32'hA5A5_0000;
      return {word, word};
   endfunction

   function automatic icache_pkg::paddr_t line_base(input icache_pkg::paddr_t a);
      return {a[`ICACHE_AW-1:`ICACHE_P_LINE], {`ICACHE_P_LINE{1'b0}}};
   endfunction

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TESTS FAILED");
      $fatal(1);
   endtask

   task automatic check_window(input string name, input icache_pkg::window_t exp,
                               input icache_pkg::window_t act);
      if (act !== exp)
         abort_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_addr(input string name, input icache_pkg::paddr_t exp,
                             input icache_pkg::paddr_t act);
      if (act !== exp)
         abort_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
   endtask

   task automatic verify_count(input string name, input int exp, input int act);
      if (act != exp)
         abort_run($sformatf("[ERROR] %s expected %0d actual %0d", name, exp, act));
   endtask

   task automatic wait_stall_low(input string name);
      int n;
      n = 0;
      while (stall_o !== 1'b0)
      begin
         @(posedge clk);
         #1;
         n = n + 1;
         if (n > TIMEOUT)
            abort_run($sformatf("Timeout: stall_o stayed high before %s", name));
      end
   endtask

   task automatic wait_fetch_done(input string name, input int idx);
      int n;
      n = 0;
      while (pop_cnt <= idx)
      begin
         @(posedge clk);
         #1;
         n = n + 1;
         if (n > TIMEOUT)
            abort_run($sformatf("Timeout: no window came back for %s", name));
      end
   endtask

   task automatic add_row(input string name, input op_t op, input icache_pkg::paddr_t addr,
                          input logic exp_ar);
      row_t r;
      r.name   = name;
      r.op     = op;
      r.addr   = addr;
      r.exp_ar = exp_ar;
      rows.push_back(r);
   endtask

   task automatic build_table();
      add_row("cold_miss",      OP_FETCH, 32'h0000_1010, 1'b1);   // Mid-line window first
      add_row("line_hit_w0",    OP_FETCH, 32'h0000_1000, 1'b0);
      add_row("line_hit_w1",    OP_FETCH, 32'h0000_1008, 1'b0);
      add_row("line_hit_w2",    OP_FETCH, 32'h0000_1010, 1'b0);
      add_row("line_hit_w3",    OP_FETCH, 32'h0000_1018, 1'b0);
      // Three lines in set 3
      add_row("set3_a_miss",    OP_FETCH, 32'h0000_2060, 1'b1);
      add_row("set3_b_miss",    OP_FETCH, 32'h0000_4068, 1'b1);
      add_row("set3_a_hit",     OP_FETCH, 32'h0000_2078, 1'b0);
      add_row("set3_b_hit",     OP_FETCH, 32'h0000_4060, 1'b0);
      add_row("set3_c_evict",   OP_FETCH, 32'h0000_8070, 1'b1);   // A is older
      add_row("set3_b_kept",    OP_FETCH, 32'h0000_4070, 1'b0);
      add_row("set3_a_refetch", OP_FETCH, 32'h0000_2060, 1'b1);
      add_row("set3_c_kept",    OP_FETCH, 32'h0000_8068, 1'b0);
      add_row("inv_line",       OP_INV,   32'h0000_1008, 1'b0);
      add_row("inv_refetch",    OP_FETCH, 32'h0000_1018, 1'b1);
      add_row("inv_hit",        OP_FETCH, 32'h0000_1000, 1'b0);
      add_row("bp_miss_a",      OP_FETCH, 32'h0001_0020, 1'b1);
      add_row("bp_miss_b",      OP_FETCH, 32'h0003_F7F8, 1'b1);
      add_row("bp_hit_a",       OP_FETCH, 32'h0001_0028, 1'b0);
      add_row("bp_hit_b",       OP_FETCH, 32'h0003_F7E0, 1'b0);
   endtask

   // Scoreboard sampled mid-cycle
   always @(negedge clk)
   begin
      if (rst_n_i)
      begin
         cyc = cyc + 1;
         if (valid_o)
         begin
            if (acc_q.size() == 0)
               abort_run("valid_o was high while no fetch was waiting for a window");
            else
            begin
               mon_addr = acc_q.pop_front();
               last_lat = cyc - acc_cyc_q.pop_front();
               pop_cnt  = pop_cnt + 1;
               check_window(cur_name, expect_window(mon_addr), ins_o);
            end
         end
         if (!stall_o)   // Taken at the coming edge
         begin
            acc_q.push_back(fetch_addr_i);
            acc_cyc_q.push_back(cyc);
            push_cnt = push_cnt + 1;
         end
         // R is open from the AR request until the last beat
         if (r_ready_o !== (ar_valid_o | rd_active))
            abort_run("r_ready_o did not follow the outstanding refill burst");
         if (ar_valid_o && ar_ready_i)
         begin
            ar_count     = ar_count + 1;
            last_ar_addr = ar_addr_o;
         end
         ar_seen   = ar_valid_o;
         ar_hs     = ar_valid_o & ar_ready_i;
         ar_addr_q = ar_addr_o;
         r_hs      = r_valid_i & r_ready_o;
      end
   end

   // AXI memory model with random AR delay and R gaps
   initial
   begin
      seed       = 17;
      ar_ready_i = 1'b0;
      r_valid_i  = 1'b0;
      r_data_i   = '0;
      r_last_i   = 1'b0;
      ar_delay   = -1;
      rd_base    = '0;
      rd_beat    = 0;
      rd_active  = 1'b0;
      forever
      begin
         @(posedge clk);
         #1;
         if (ar_hs)
         begin
            ar_ready_i = 1'b0;
            ar_delay   = -1;
            rd_base    = ar_addr_q;
            rd_beat    = 0;
            rd_active  = 1'b1;
         end
         else if (ar_seen && !rd_active)
         begin
            if (ar_delay < 0)
               ar_delay = $unsigned($random(seed)) % 4;   // 0 to 3 cycles
            if (ar_delay == 0)
               ar_ready_i = 1'b1;
            else
               ar_delay = ar_delay - 1;
         end
         if (r_hs)
            rd_beat = rd_beat + 1;
         if (rd_active && rd_beat == `ICACHE_BEATS)
         begin
            rd_active = 1'b0;
            r_valid_i = 1'b0;
            r_last_i  = 1'b0;
         end
         else if (rd_active && (r_hs || !r_valid_i))
         begin
            if (($random(seed) & 3) == 0)
               r_valid_i = 1'b0;   // Gap
            else
            begin
               r_valid_i = 1'b1;
               r_data_i  = expect_window(rd_base + (rd_beat << `ICACHE_P_WIN));
               r_last_i  = (rd_beat == `ICACHE_BEATS - 1);
            end
         end
      end
   end

   initial
   begin
      int     idx;
      int     ar_base;
      row_t   r;
      rst_n_i      = 1'b0;
      fetch_addr_i = '0;
      inv_i        = 1'b0;
      inv_addr_i   = '0;
      build_table();
      repeat (8) @(posedge clk);
      #1;
      rst_n_i = 1'b1;
      wait_stall_low("boot");   // Tag clear after reset
      for (int i = 0; i < rows.size(); i++)
      begin
         r = rows[i];
         wait_stall_low(r.name);
         cur_name = r.name;
         ar_base  = ar_count;
         if (r.op == OP_FETCH)
         begin
            fetch_addr_i = r.addr;
            idx          = push_cnt;
            wait_fetch_done(r.name, idx);
            verify_count({r.name, " bursts"}, r.exp_ar ? 1 : 0, ar_count - ar_base);
            if (r.exp_ar)
               check_addr(r.name, line_base(r.addr), last_ar_addr);
            else
               verify_count({r.name, " latency"}, 2, last_lat);
         end
         else
         begin
            inv_addr_i = r.addr;
            inv_i      = 1'b1;
            @(negedge clk);
            verify_count({r.name, " op_stall"}, 1, int'(op_stall_o));
            @(posedge clk);
            #1;
            inv_i = 1'b0;
            verify_count({r.name, " stall"}, 1, int'(stall_o));
            verify_count({r.name, " op_stall held"}, 1, int'(op_stall_o));
            @(posedge clk);
            #1;
            verify_count({r.name, " op_stall release"}, 0, int'(op_stall_o));
         end
      end
      $display("TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- icache_top.f
+incdir+source
source/icache_pkg.sv
source/icache_ram_if.sv
source/icache_sram.sv
source/icache_ways.sv
source/icache_ctrl.sv
source/icache_top.sv
dv/icache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the cache testbench with Verilator and run it
# The exit status of the simulation is the result
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
   --top-module icache_tb \
   -f icache_top.f \
   -o icache_sim

./obj_dir/icache_sim
